//--- abus_pkg.sv
// ----------------------------------------------------------
// Shared widths, types and field positions for the address
// bus unit. The bus address is 24 bits and DRAM rows and
// columns are 11 bits. Register fields sit at the bit
// positions below. Bits that are not listed read back as 0.
// ----------------------------------------------------------
package abus_pkg;

	// Bus, DRAM pin and register widths
	localparam int ADDR_W = 24;
	localparam int MA_W   = 11;
	localparam int REG_W  = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [MA_W-1:0]   ma_t;
	typedef logic [REG_W-1:0]  reg_t;

	// Memory width code, 0 is 8 bit up to 3 for 64 bit
	typedef logic [1:0] width_t;

	// One select line per region
	typedef logic [3:0] bank_sel_t;

	// Bit index of each region in a bank select
	localparam int BS_BIOS  = 0;
	localparam int BS_CART  = 1;
	localparam int BS_DRAM1 = 2;
	localparam int BS_DRAM0 = 3;

	// MEMCON1 fields
	localparam int ROMHI_BIT  = 0;
	localparam int ROMWID_LSB = 1;

	// MEMCON2 fields, column count and width per DRAM bank
	localparam int COLS0_LSB = 0;
	localparam int DWID0_LSB = 2;
	localparam int COLS1_LSB = 4;
	localparam int DWID1_LSB = 6;

	// Lowest address bit of the row field before the column shift
	localparam int ROW_BASE = 8;

	// Internal devices answer on bits 20 to 16 of a BIOS cycle
	localparam logic [4:0] DEV_HI = 5'b10000;

endpackage

//--- abus_top.sv
// ----------------------------------------------------------
// Address bus unit top level.
// newrow opens a row in the selected DRAM bank. match flags a
// page hit for the bank of the latched cycle.
// ----------------------------------------------------------
module abus_top import abus_pkg::*; (
	input  logic      sys_clk,
	input  logic      resetl,
	input  reg_t      din,
	input  logic      mem_w1,
	input  logic      mem_w2,
	input  logic      mem_r1,
	input  logic      mem_r2,
	input  addr_t     a_in,
	input  logic      mreq,
	input  logic      ack,
	input  logic      mux,
	input  logic      newrow,
	input  logic      resrow,
	output reg_t      dr_out,
	output logic      dr_oe,
	output bank_sel_t bs,
	output logic      dram,
	output logic      from,
	output logic      fintdev,
	output width_t    mw,
	output ma_t       ma,
	output logic      match
);

	logic   romhi;
	logic   mset;
	width_t romwid;
	width_t cols0;
	width_t dwid0;
	width_t cols1;
	width_t dwid1;
	addr_t  cycle_addr;
	ma_t    row0;
	ma_t    row1;
	logic   load0;
	logic   load1;
	logic   hit0;
	logic   hit1;

	mem_config_regs u_regs (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.din     (din),
		.mem_w1  (mem_w1),
		.mem_w2  (mem_w2),
		.mem_r1  (mem_r1),
		.mem_r2  (mem_r2),
		.dr_out  (dr_out),
		.dr_oe   (dr_oe),
		.romhi   (romhi),
		.romwid  (romwid),
		.cols0   (cols0),
		.dwid0   (dwid0),
		.cols1   (cols1),
		.dwid1   (dwid1),
		.mset    (mset)
	);

	addr_decode u_decode (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.a_in       (a_in),
		.mreq       (mreq),
		.ack        (ack),
		.mset       (mset),
		.romhi      (romhi),
		.romwid     (romwid),
		.dwid0      (dwid0),
		.dwid1      (dwid1),
		.cycle_addr (cycle_addr),
		.bs         (bs),
		.dram       (dram),
		.from       (from),
		.fintdev    (fintdev),
		.mw         (mw)
	);

	dram_addr_mux u_mux (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.cycle_addr (cycle_addr),
		.bank1_sel  (bs[BS_DRAM1]),
		.mux        (mux),
		.cols0      (cols0),
		.dwid0      (dwid0),
		.cols1      (cols1),
		.dwid1      (dwid1),
		.ma         (ma),
		.row0       (row0),
		.row1       (row1)
	);

	// A new row only opens in the bank of the current cycle
	assign load0 = newrow & bs[BS_DRAM0];
	assign load1 = newrow & bs[BS_DRAM1];

	page_tracker bank0_page (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.row     (row0),
		.load    (load0),
		.resrow  (resrow),
		.hit     (hit0)
	);

	page_tracker bank1_page (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.row     (row1),
		.load    (load1),
		.resrow  (resrow),
		.hit     (hit1)
	);

	// Page hit counts only for the bank that is selected
	assign match = (hit0 & bs[BS_DRAM0]) | (hit1 & bs[BS_DRAM1]);

endmodule

//--- addr_decode.sv
// ----------------------------------------------------------
// Bus cycle decode. The address and its decode are latched on
// an edge with ack high and hold until the next ack.
// Before mset every request maps to the BIOS. romhi flips the
// region layout. Outputs are 0 for cycles without mreq.
// ----------------------------------------------------------
module addr_decode import abus_pkg::*; (
	input  logic      sys_clk,
	input  logic      resetl,
	input  addr_t     a_in,
	input  logic      mreq,
	input  logic      ack,
	input  logic      mset,
	input  logic      romhi,
	input  width_t    romwid,
	input  width_t    dwid0,
	input  width_t    dwid1,
	output addr_t     cycle_addr,
	output bank_sel_t bs,
	output logic      dram,
	output logic      from,
	output logic      fintdev,
	output width_t    mw
);

	logic [1:0] a_top2;
	logic [2:0] a_top3;
	bank_sel_t  bs_d;
	logic       dram_d;
	logic       from_d;
	logic       fintdev_d;
	width_t     mw_d;

	// Region decode uses the top two or three address bits
	assign a_top2 = a_in[ADDR_W-1 -: 2];
	assign a_top3 = a_in[ADDR_W-1 -: 3];

	always_comb begin
		bs_d = '0;
		if (mreq) begin
			if (!mset) begin
				// Boot time, everything is BIOS
				bs_d[BS_BIOS] = 1'b1;
			end else if (!romhi) begin
				// ROM low, DRAM in the top half
				case (a_top2)
					2'b00: begin
						if (a_top3 == 3'b000) begin
							bs_d[BS_BIOS] = 1'b1;
						end else begin
							bs_d[BS_CART] = 1'b1;
						end
					end
					2'b01: bs_d[BS_CART] = 1'b1;
					2'b10: bs_d[BS_DRAM1] = 1'b1;
					default: bs_d[BS_DRAM0] = 1'b1;
				endcase
			end else begin
				// ROM high, DRAM in the bottom half
				case (a_top2)
					2'b11: begin
						if (a_top3 == 3'b111) begin
							bs_d[BS_BIOS] = 1'b1;
						end else begin
							bs_d[BS_CART] = 1'b1;
						end
					end
					2'b10: bs_d[BS_CART] = 1'b1;
					2'b01: bs_d[BS_DRAM1] = 1'b1;
					default: bs_d[BS_DRAM0] = 1'b1;
				endcase
			end
		end
	end

	assign from_d = bs_d[BS_BIOS] | bs_d[BS_CART];
	assign dram_d = bs_d[BS_DRAM1] | bs_d[BS_DRAM0];

	// Internal devices live inside the BIOS window
	assign fintdev_d = bs_d[BS_BIOS] & (a_in[20:16] == DEV_HI);

	// Width follows the region that was hit
	always_comb begin
		if (bs_d[BS_DRAM1]) begin
			mw_d = dwid1;
		end else if (bs_d[BS_DRAM0]) begin
			mw_d = dwid0;
		end else if (from_d) begin
			mw_d = romwid;
		end else begin
			mw_d = '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cycle_addr <= '0;
			bs         <= '0;
			dram       <= 1'b0;
			from       <= 1'b0;
			fintdev    <= 1'b0;
			mw         <= '0;
		end else if (ack) begin
			cycle_addr <= a_in;
			bs         <= bs_d;
			dram       <= dram_d;
			from       <= from_d;
			fintdev    <= fintdev_d;
			mw         <= mw_d;
		end
	end

endmodule

//--- dram_addr_mux.sv
// ----------------------------------------------------------
// DRAM row and column address selection.
// The row starts at bit 8 plus cols plus dwid of the bank.
// The column starts at bit dwid. ma is registered, so it
// follows mux and cycle_addr one edge later.
// ----------------------------------------------------------
module dram_addr_mux import abus_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetl,
	input  addr_t  cycle_addr,
	input  logic   bank1_sel,
	input  logic   mux,
	input  width_t cols0,
	input  width_t dwid0,
	input  width_t cols1,
	input  width_t dwid1,
	output ma_t    ma,
	output ma_t    row0,
	output ma_t    row1
);

	width_t dwid_act;
	addr_t  col_shifted;
	ma_t    col_addr;
	ma_t    row_act;

	// Row field of an address for one bank geometry
	// Bits above the top of the bus shift in as zeros
	function automatic ma_t row_of(addr_t a, width_t cols, width_t dwid);
		logic [4:0] k;
		addr_t      sh;
		k  = 5'(ROW_BASE) + {3'b000, cols} + {3'b000, dwid};
		sh = a >> k;
		return sh[MA_W-1:0];
	endfunction

	// Each bank has its own row shift, the trackers need both
	assign row0 = row_of(cycle_addr, cols0, dwid0);
	assign row1 = row_of(cycle_addr, cols1, dwid1);

	// Bank 1 wins when its select is set
	assign dwid_act = bank1_sel ? dwid1 : dwid0;
	assign row_act  = bank1_sel ? row1 : row0;

	// Column drops the byte offset within a data word
	assign col_shifted = cycle_addr >> dwid_act;
	assign col_addr    = col_shifted[MA_W-1:0];

	// mux high puts the row on the pins
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			ma <= '0;
		end else begin
			ma <= mux ? row_act : col_addr;
		end
	end

endmodule

//--- mem_config_regs.sv
// ----------------------------------------------------------
// MEMCON1 and MEMCON2 configuration registers.
// A write strobe loads din on the same edge, so the new value
// is seen one cycle later. Read-back is combinational and
// reads 0 when no read strobe is high.
// ----------------------------------------------------------
module mem_config_regs import abus_pkg::*; (
	input  logic   sys_clk,
	input  logic   resetl,
	input  reg_t   din,
	input  logic   mem_w1,
	input  logic   mem_w2,
	input  logic   mem_r1,
	input  logic   mem_r2,
	output reg_t   dr_out,
	output logic   dr_oe,
	output logic   romhi,
	output width_t romwid,
	output width_t cols0,
	output width_t dwid0,
	output width_t cols1,
	output width_t dwid1,
	output logic   mset
);

	reg_t memcon1_rb;
	reg_t memcon2_rb;

	// MEMCON1 holds the ROM placement and ROM width
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			romhi  <= 1'b0;
			romwid <= '0;
		end else if (mem_w1) begin
			romhi  <= din[ROMHI_BIT];
			romwid <= din[ROMWID_LSB +: 2];
		end
	end

	// MEMCON2 holds column count and data width of both DRAM banks
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cols0 <= '0;
			dwid0 <= '0;
			cols1 <= '0;
			dwid1 <= '0;
		end else if (mem_w2) begin
			cols0 <= din[COLS0_LSB +: 2];
			dwid0 <= din[DWID0_LSB +: 2];
			cols1 <= din[COLS1_LSB +: 2];
			dwid1 <= din[DWID1_LSB +: 2];
		end
	end

	// Memory map becomes live with the first MEMCON1 write
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			mset <= 1'b0;
		end else if (mem_w1) begin
			mset <= 1'b1;
		end
	end

	// Rebuild both words with unused bits at 0
	always_comb begin
		memcon1_rb = '0;
		memcon1_rb[ROMHI_BIT] = romhi;
		memcon1_rb[ROMWID_LSB +: 2] = romwid;
		memcon2_rb = '0;
		memcon2_rb[COLS0_LSB +: 2] = cols0;
		memcon2_rb[DWID0_LSB +: 2] = dwid0;
		memcon2_rb[COLS1_LSB +: 2] = cols1;
		memcon2_rb[DWID1_LSB +: 2] = dwid1;
	end

	// Shared read bus, each word only drives while its strobe is up
	assign dr_out = (mem_r1 ? memcon1_rb : '0) | (mem_r2 ? memcon2_rb : '0);
	assign dr_oe  = mem_r1 | mem_r2;

endmodule

//--- page_tracker.sv
// ----------------------------------------------------------
// Open-row tracker for one DRAM bank.
// load wins over resrow. hit is combinational and only
// valid once a row has been opened since reset or resrow.
// ----------------------------------------------------------
module page_tracker import abus_pkg::*; (
	input  logic sys_clk,
	input  logic resetl,
	input  ma_t  row,
	input  logic load,
	input  logic resrow,
	output logic hit
);

	ma_t  open_row;
	logic valid;

	// Row that is currently open in the bank
	always_ff @(posedge sys_clk) begin
		if (load) begin
			open_row <= row;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			valid <= 1'b0;
		end else if (load) begin
			valid <= 1'b1;
		end else if (resrow) begin
			// Row closed by precharge or refresh
			valid <= 1'b0;
		end
	end

	assign hit = valid & (open_row == row);

endmodule

//--- run.sh
#!/bin/sh
# Build the address bus testbench with Verilator and run it
verilator --binary --timing --top-module tb_abus -f vlog.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_abus > sim.log 2>&1 || echo "simulation returned a failing status" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

//--- tb_abus.sv
// ----------------------------------------------------------
// Testbench for the address bus unit. Inputs change on the
// falling clock edge, and the compare process samples on the
// rising edge. The first error stops the run.
// Expected values come from a small model of the registers,
// the latched cycle and both open-row trackers.
// ----------------------------------------------------------
module tb_abus import abus_pkg::*; ();

	logic      sys_clk;
	logic      resetl;
	reg_t      din;
	logic      mem_w1;
	logic      mem_w2;
	logic      mem_r1;
	logic      mem_r2;
	addr_t     a_in;
	logic      mreq;
	logic      ack;
	logic      mux;
	logic      newrow;
	logic      resrow;
	reg_t      dr_out;
	logic      dr_oe;
	bank_sel_t bs;
	logic      dram;
	logic      from;
	logic      fintdev;
	width_t    mw;
	ma_t       ma;
	logic      match;

	// Model of the configuration registers
	logic   m_romhi;
	logic   m_mset;
	width_t m_romwid;
	width_t m_cols0;
	width_t m_dwid0;
	width_t m_cols1;
	width_t m_dwid1;
	reg_t   m_con1;
	reg_t   m_con2;

	// Model of the latched cycle and the trackers
	addr_t     m_addr;
	bank_sel_t m_bs;
	logic      m_valid0;
	logic      m_valid1;
	ma_t       m_open0;
	ma_t       m_open1;

	// Expected values and their enables for the compare process
	logic       chk_reg;
	logic       chk_dec;
	logic       chk_ma;
	logic       chk_match;
	reg_t       exp_dr;
	logic       exp_oe;
	logic [8:0] exp_dec;
	ma_t        exp_ma;
	logic       exp_match;

	integer      seed;
	logic [31:0] rnd;
	addr_t       base;

	abus_top dut0 (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.din     (din),
		.mem_w1  (mem_w1),
		.mem_w2  (mem_w2),
		.mem_r1  (mem_r1),
		.mem_r2  (mem_r2),
		.a_in    (a_in),
		.mreq    (mreq),
		.ack     (ack),
		.mux     (mux),
		.newrow  (newrow),
		.resrow  (resrow),
		.dr_out  (dr_out),
		.dr_oe   (dr_oe),
		.bs      (bs),
		.dram    (dram),
		.from    (from),
		.fintdev (fintdev),
		.mw      (mw),
		.ma      (ma),
		.match   (match)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// Expected {bs, dram, from, fintdev, mw} from the memory map ranges
	function automatic logic [8:0] decode_ref(addr_t a, logic req);
		bank_sel_t b;
		width_t    w;
		logic      dev;
		b = 4'b0000;
		if (req && !m_mset) begin
			b = 4'b0001;
		end else if (req && !m_romhi) begin
			if (a < 24'h200000) b = 4'b0001;
			else if (a < 24'h800000) b = 4'b0010;
			else if (a < 24'hC00000) b = 4'b0100;
			else b = 4'b1000;
		end else if (req) begin
			if (a >= 24'hE00000) b = 4'b0001;
			else if (a >= 24'h800000) b = 4'b0010;
			else if (a >= 24'h400000) b = 4'b0100;
			else b = 4'b1000;
		end
		if (b[3]) w = m_dwid0;
		else if (b[2]) w = m_dwid1;
		else if (b[1] || b[0]) w = m_romwid;
		else w = 2'd0;
		dev = b[0] && (a[20:16] == DEV_HI);
		return {b, b[3] | b[2], b[1] | b[0], dev, w};
	endfunction

	// Row field for one bank geometry, zeros above bit 23
	function automatic ma_t row_ref(addr_t a, width_t cols, width_t dwid);
		addr_t s;
		s = a >> (ROW_BASE + int'(cols) + int'(dwid));
		return s[MA_W-1:0];
	endfunction

	function automatic ma_t ma_ref(addr_t a, logic bank1, logic m);
		addr_t s;
		if (m) begin
			return bank1 ? row_ref(a, m_cols1, m_dwid1) : row_ref(a, m_cols0, m_dwid0);
		end
		s = a >> (bank1 ? m_dwid1 : m_dwid0);
		return s[MA_W-1:0];
	endfunction

	// Page hit of the latched cycle against the open rows
	function automatic logic match_ref();
		logic h0;
		logic h1;
		h0 = m_valid0 && (m_open0 == row_ref(m_addr, m_cols0, m_dwid0)) && m_bs[3];
		h1 = m_valid1 && (m_open1 == row_ref(m_addr, m_cols1, m_dwid1)) && m_bs[2];
		return h0 || h1;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_reg(input string name, input reg_t got, input reg_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bank(input string name, input bank_sel_t got, input bank_sel_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_width(input string name, input width_t got, input width_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ma(input string name, input ma_t got, input ma_t exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	// Compare on the rising edge, inputs have been stable since the falling one
	always @(posedge sys_clk) begin
		if (chk_reg) begin
			check_reg("dr_out", dr_out, exp_dr);
			check_bit("dr_oe", dr_oe, exp_oe);
		end
		if (chk_dec) begin
			check_bank("bs", bs, exp_dec[8:5]);
			check_bit("dram", dram, exp_dec[4]);
			check_bit("from", from, exp_dec[3]);
			check_bit("fintdev", fintdev, exp_dec[2]);
			check_width("mw", mw, exp_dec[1:0]);
		end
		if (chk_ma) begin
			check_ma("ma", ma, exp_ma);
		end
		if (chk_match) begin
			check_bit("match", match, exp_match);
		end
	end

	task automatic tick(input int n);
		repeat (n) @(negedge sys_clk);
	endtask

	// Register write, the model follows the field layout
	task automatic write_reg(input logic second, input reg_t v);
		din = v;
		mem_w1 = !second;
		mem_w2 = second;
		tick(1);
		mem_w1 = 1'b0;
		mem_w2 = 1'b0;
		if (!second) begin
			m_romhi = v[0];
			m_romwid = v[2:1];
			m_mset = 1'b1;
			m_con1 = v & 16'h0007;
		end else begin
			m_cols0 = v[1:0];
			m_dwid0 = v[3:2];
			m_cols1 = v[5:4];
			m_dwid1 = v[7:6];
			m_con2 = v & 16'h00ff;
		end
	endtask

	// One read strobe cycle, the bus idles at 0 again afterwards
	task automatic read_reg(input logic second);
		mem_r1 = !second;
		mem_r2 = second;
		exp_dr = second ? m_con2 : m_con1;
		exp_oe = 1'b1;
		tick(1);
		mem_r1 = 1'b0;
		mem_r2 = 1'b0;
		exp_dr = '0;
		exp_oe = 1'b0;
	endtask

	// One acked cycle, decode checked one cycle later
	task automatic bus_cycle(input addr_t a, input logic req);
		a_in = a;
		mreq = req;
		ack = 1'b1;
		tick(1);
		ack = 1'b0;
		mreq = 1'b0;
		exp_dec = decode_ref(a, req);
		m_addr = a;
		m_bs = exp_dec[8:5];
		chk_dec = 1'b1;
		tick(1);
		chk_dec = 1'b0;
	endtask

	task automatic ma_phase(input logic m);
		mux = m;
		tick(1);
		exp_ma = ma_ref(m_addr, m_bs[2], m);
		chk_ma = 1'b1;
		tick(1);
		chk_ma = 1'b0;
	endtask

	task automatic open_row();
		newrow = 1'b1;
		tick(1);
		newrow = 1'b0;
		if (m_bs[3]) begin
			m_valid0 = 1'b1;
			m_open0 = row_ref(m_addr, m_cols0, m_dwid0);
		end
		if (m_bs[2]) begin
			m_valid1 = 1'b1;
			m_open1 = row_ref(m_addr, m_cols1, m_dwid1);
		end
	endtask

	task automatic close_rows();
		resrow = 1'b1;
		tick(1);
		resrow = 1'b0;
		m_valid0 = 1'b0;
		m_valid1 = 1'b0;
	endtask

	task automatic match_now(input logic e);
		exp_match = e;
		chk_match = 1'b1;
		tick(1);
		chk_match = 1'b0;
	endtask

	initial begin
		seed = 32'h1556_b3ce;
		resetl = 1'b0;
		din = '0;
		mem_w1 = 1'b0;
		mem_w2 = 1'b0;
		mem_r1 = 1'b0;
		mem_r2 = 1'b0;
		a_in = '0;
		mreq = 1'b0;
		ack = 1'b0;
		mux = 1'b0;
		newrow = 1'b0;
		resrow = 1'b0;
		{chk_reg, chk_dec, chk_ma, chk_match} = 4'b0000;
		{m_romhi, m_mset, m_valid0, m_valid1} = 4'b0000;
		{m_romwid, m_cols0, m_dwid0, m_cols1, m_dwid1} = '0;
		m_con1 = '0;
		m_con2 = '0;
		m_addr = '0;
		m_bs = '0;
		m_open0 = '0;
		m_open1 = '0;
		tick(5);
		resetl = 1'b1;

		// Outputs all start at 0, read bus stays watched from here on
		exp_dr = '0;
		exp_oe = 1'b0;
		exp_dec = '0;
		exp_ma = '0;
		exp_match = 1'b0;
		{chk_reg, chk_dec, chk_ma, chk_match} = 4'b1111;
		tick(1);
		{chk_dec, chk_ma, chk_match} = 3'b000;

		// Reset values, then BIOS for every request before mset
		read_reg(1'b0);
		read_reg(1'b1);
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			bus_cycle(rnd[23:0], 1'b1);
		end
		bus_cycle(24'hC12345, 1'b0);

		// Write and read back with undefined bits masked
		for (int i = 0; i < 10; i++) begin
			rnd = $random(seed);
			write_reg(1'b0, rnd[15:0]);
			rnd = $random(seed);
			write_reg(1'b1, rnd[15:0]);
			read_reg(1'b0);
			read_reg(1'b1);
		end

		// Decode under both ROM placements, mreq mostly high
		for (int h = 0; h < 2; h++) begin
			rnd = $random(seed);
			write_reg(1'b0, {rnd[15:1], h[0]});
			rnd = $random(seed);
			write_reg(1'b1, rnd[15:0]);
			// Internal device window in the high and the low BIOS
			bus_cycle(24'hF00000, 1'b1);
			bus_cycle(24'h100000, 1'b1);
			for (int i = 0; i < 40; i++) begin
				rnd = $random(seed);
				bus_cycle(rnd[23:0], rnd[31:30] != 2'b00);
			end
		end

		// Row and column address on the pins
		for (int i = 0; i < 30; i++) begin
			rnd = $random(seed);
			if (rnd[31]) begin
				write_reg(1'b1, rnd[15:0]);
			end
			rnd = $random(seed);
			bus_cycle(rnd[23:0], 1'b1);
			ma_phase(1'b1);
			ma_phase(1'b0);
		end

		// Page hits, ROM low puts bank 1 at 800000 and bank 0 at C00000
		write_reg(1'b0, 16'h0000);
		for (int b = 0; b < 2; b++) begin
			rnd = $random(seed);
			base = {1'b1, b == 0, rnd[21:0]};
			bus_cycle(base, 1'b1);
			open_row();
			match_now(1'b1);
			// Bit 0 is never part of the row
			bus_cycle(base ^ 24'h000001, 1'b1);
			match_now(1'b1);
			// Bit 14 is always part of the row
			bus_cycle(base ^ 24'h004000, 1'b1);
			match_now(1'b0);
			bus_cycle(base, 1'b1);
			close_rows();
			match_now(1'b0);
		end

		// Mixed opens and closes against the tracker model
		for (int i = 0; i < 24; i++) begin
			rnd = $random(seed);
			bus_cycle({1'b1, rnd[22], 7'h00, rnd[14:0]}, 1'b1);
			if (rnd[29]) open_row();
			if (rnd[28] && !rnd[29]) close_rows();
			match_now(match_ref());
		end

		$display("All tests passed");
		$finish;
	end

endmodule

//--- vlog.f
abus_pkg.sv
mem_config_regs.sv
addr_decode.sv
dram_addr_mux.sv
page_tracker.sv
abus_top.sv
tb_abus.sv
